/* hw/cam_pkg.sv */
// shared widths, APB constants and the camera byte-pair union
`default_nettype none

package cam_pkg;

	// ======================================================================
	// widths
	// ======================================================================

	// one camera data byte
	localparam int BYTE_W = 8;
	// stored RGB332 pixel
	localparam int PIXEL_W = 8;

	// APB host read port
	localparam int APB_DATA_W = 32;
	// pixel index, not a byte address
	localparam int APB_ADDR_W = 16;

	// ======================================================================
	// byte pair, seen as two camera bytes or as RGB565 fields
	// ======================================================================

	// first byte arrives first and lands in the low half
	// first byte = green low bits + blue, second = red + green high bits
	typedef union packed {
		struct packed {
			logic [BYTE_W-1:0] second;
			logic [BYTE_W-1:0] first;
		} bytes;
		struct packed {
			logic [4:0] red;
			logic [5:0] green;
			logic [4:0] blue;
		} rgb;
	} pixel_pair_u;

endpackage

`default_nettype wire

/* hw/cam_sync_decode.sv */
// camera framing edge detection and byte pairing into RGB565 words
`timescale 1ns/1ns
`default_nettype none

module cam_sync_decode (
	input  wire                         PCLK,
	input  wire                         reset,
	input  wire                         vsync,
	input  wire                         href,
	input  wire [cam_pkg::BYTE_W-1:0]   cam_data,
	output logic                        pair_valid,
	output cam_pkg::pixel_pair_u        pair,
	output logic                        frame_start,
	output logic                        line_end
);

	// previous samples of the sync pins
	logic vsync_q;
	logic href_q;

	// 0 = waiting for first byte, 1 = waiting for second
	logic byte_phase;
	// first byte held until its partner shows up
	logic [cam_pkg::BYTE_W-1:0] first_byte;

	// edges seen on this sample
	logic vsync_rise;
	logic href_fall;

	assign vsync_rise = vsync & ~vsync_q;
	assign href_fall  = ~href & href_q;

	// sync history and framing pulses
	always_ff @(posedge PCLK) begin
		if (reset) begin
			vsync_q     <= 1'b0;
			href_q      <= 1'b0;
			frame_start <= 1'b0;
			line_end    <= 1'b0;
		end else begin
			vsync_q     <= vsync;
			href_q      <= href;
			// one-cycle pulses
			frame_start <= vsync_rise;
			line_end    <= href_fall;
		end
	end

	// byte phase tracking
	// framing event drops a half-built pair (odd trailing byte)
	always_ff @(posedge PCLK) begin
		if (reset) begin
			byte_phase <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= 1'b0;
			if (vsync_rise || href_fall) begin
				byte_phase <= 1'b0;
			end else if (href) begin
				byte_phase <= ~byte_phase;
				// only the second byte completes a pixel
				pair_valid <= byte_phase;
			end
		end
	end

	// payload capture on each sampled byte
	always_ff @(posedge PCLK) begin
		if (href && !vsync_rise) begin
			if (!byte_phase) begin
				first_byte <= cam_data;
			end else begin
				pair.bytes.first  <= first_byte;
				pair.bytes.second <= cam_data;
			end
		end
	end

	// pairs need two bytes and never come back to back
	a_pair_spacing: assert property (
		@(posedge PCLK) disable iff (reset)
		pair_valid |=> !pair_valid
	);

endmodule

`default_nettype wire

/* hw/pixel_downsample.sv */
// RGB565 to RGB332 reduction stage with framing flags carried alongside
`timescale 1ns/1ns
`default_nettype none

module pixel_downsample (
	input  wire                          PCLK,
	input  wire                          reset,
	input  wire                          pair_valid,
	input  cam_pkg::pixel_pair_u         pair,
	input  wire                          frame_start,
	input  wire                          line_end,
	output logic                         pixel_valid,
	output logic [cam_pkg::PIXEL_W-1:0]  pixel,
	output logic                         pix_frame_start,
	output logic                         pix_line_end
);

	// reduced colour before the register
	logic [cam_pkg::PIXEL_W-1:0] rgb332;

	// red 3 msbs, green 3 msbs, blue 2 msbs
	assign rgb332 = {pair.rgb.red[4:2], pair.rgb.green[5:3], pair.rgb.blue[4:3]};

	// flags all delayed by the same stage
	// keeps frame/line events in order with the pixels
	always_ff @(posedge PCLK) begin
		if (reset) begin
			pixel_valid     <= 1'b0;
			pix_frame_start <= 1'b0;
			pix_line_end    <= 1'b0;
		end else begin
			pixel_valid     <= pair_valid;
			pix_frame_start <= frame_start;
			pix_line_end    <= line_end;
		end
	end

	// colour payload
	always_ff @(posedge PCLK) begin
		if (pair_valid) begin
			pixel <= rgb332;
		end
	end

endmodule

`default_nettype wire

/* hw/frame_write_addr.sv */
// x/y pixel counters, frame buffer write address and screen clipping
`timescale 1ns/1ns
`default_nettype none

module frame_write_addr #(
	parameter int SCREEN_WIDTH  = 176,
	parameter int SCREEN_HEIGHT = 144,
	localparam int FRAME_SIZE   = SCREEN_WIDTH * SCREEN_HEIGHT,
	localparam int ADDR_W       = $clog2(FRAME_SIZE)
) (
	input  wire                          PCLK,
	input  wire                          reset,
	input  wire                          pixel_valid,
	input  wire [cam_pkg::PIXEL_W-1:0]   pixel,
	input  wire                          pix_frame_start,
	input  wire                          pix_line_end,
	output logic                         wr_en,
	output logic [ADDR_W-1:0]            wr_addr,
	output logic [cam_pkg::PIXEL_W-1:0]  wr_data
);

	// counters go one past the screen edge and stick there
	localparam int X_W = $clog2(SCREEN_WIDTH + 1);
	localparam int Y_W = $clog2(SCREEN_HEIGHT + 1);

	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;
	logic           in_screen;

	assign in_screen = (x < X_W'(SCREEN_WIDTH)) && (y < Y_W'(SCREEN_HEIGHT));

	// write lands on the edge where pixel_valid is high
	assign wr_en   = pixel_valid && in_screen;
	// x + y * width
	assign wr_addr = ADDR_W'(x) + ADDR_W'(y) * ADDR_W'(SCREEN_WIDTH);
	assign wr_data = pixel;

	// ======================================================================
	// position counters
	// ======================================================================

	always_ff @(posedge PCLK) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (pix_frame_start) begin
			x <= '0;
			y <= '0;
		end else if (pix_line_end) begin
			x <= '0;
			// extra lines past the bottom are dropped
			if (y != Y_W'(SCREEN_HEIGHT)) begin
				y <= y + 1'b1;
			end
		end else if (pixel_valid && (x != X_W'(SCREEN_WIDTH))) begin
			x <= x + 1'b1;
		end
	end

	// clipping must keep every write inside the memory
	a_wr_in_frame: assert property (
		@(posedge PCLK) disable iff (reset)
		wr_en |-> (int'(wr_addr) < FRAME_SIZE)
	);

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
// pixel memory with camera write port and APB read slave
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
	parameter int SCREEN_WIDTH  = 176,
	parameter int SCREEN_HEIGHT = 144,
	localparam int FRAME_SIZE   = SCREEN_WIDTH * SCREEN_HEIGHT,
	localparam int ADDR_W       = $clog2(FRAME_SIZE)
) (
	input  wire                             PCLK,
	input  wire                             reset,
	// camera side
	input  wire                             wr_en,
	input  wire [ADDR_W-1:0]                wr_addr,
	input  wire [cam_pkg::PIXEL_W-1:0]      wr_data,
	// APB slave
	input  wire                             psel,
	input  wire                             penable,
	input  wire                             pwrite,
	input  wire [cam_pkg::APB_ADDR_W-1:0]   paddr,
	input  wire [cam_pkg::APB_DATA_W-1:0]   pwdata,
	output logic [cam_pkg::APB_DATA_W-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr
);

	// one RGB332 pixel per screen position
	logic [cam_pkg::PIXEL_W-1:0] mem [FRAME_SIZE];
	logic [cam_pkg::PIXEL_W-1:0] rd_pixel;

	// first access cycle is the wait state
	logic access_first;
	logic in_range;
	logic bad_access;

	assign access_first = psel && penable && !pready;
	assign in_range     = int'(paddr) < FRAME_SIZE;
	// writes are never allowed
	assign bad_access   = pwrite || !in_range;

	// ======================================================================
	// memory
	// ======================================================================

	// camera write port
	always_ff @(posedge PCLK) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read during the wait state
	// a same-edge camera write is not visible yet so the old value comes back
	always_ff @(posedge PCLK) begin
		if (access_first && !bad_access) begin
			rd_pixel <= mem[paddr[ADDR_W-1:0]];
		end
	end

	// ======================================================================
	// APB access phase
	// ======================================================================

	// pready on the second access cycle
	always_ff @(posedge PCLK) begin
		if (reset) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready  <= access_first;
			pslverr <= access_first && bad_access;
		end
	end

	// pixel in the low bits and zero on error or idle
	assign prdata = (pready && !pslverr) ?
		{{(cam_pkg::APB_DATA_W - cam_pkg::PIXEL_W){1'b0}}, rd_pixel} : '0;

	// completion only inside an access phase
	a_pready_in_access: assert property (
		@(posedge PCLK) disable iff (reset)
		pready |-> (psel && penable)
	);

endmodule

`default_nettype wire

/* hw/cam_capture_top.sv */
// camera capture top: sync decode, downsample, write addressing, frame buffer
`timescale 1ns/1ns
`default_nettype none

module cam_capture_top #(
	parameter int SCREEN_WIDTH  = 176,
	parameter int SCREEN_HEIGHT = 144
) (
	input  wire                             PCLK,
	input  wire                             reset,
	// camera
	input  wire                             vsync,
	input  wire                             href,
	input  wire [cam_pkg::BYTE_W-1:0]       cam_data,
	// APB host read port
	input  wire                             psel,
	input  wire                             penable,
	input  wire                             pwrite,
	input  wire [cam_pkg::APB_ADDR_W-1:0]   paddr,
	input  wire [cam_pkg::APB_DATA_W-1:0]   pwdata,
	output logic [cam_pkg::APB_DATA_W-1:0]  prdata,
	output logic                            pready,
	output logic                            pslverr
);

	// write address width, same rule as the submodules
	localparam int WR_ADDR_W = $clog2(SCREEN_WIDTH * SCREEN_HEIGHT);

	// byte pairs
	logic                         pair_valid;
	cam_pkg::pixel_pair_u         pair;
	logic                         frame_start;
	logic                         line_end;
	// downsampled pixels
	logic                         pixel_valid;
	logic [cam_pkg::PIXEL_W-1:0]  pixel;
	logic                         pix_frame_start;
	logic                         pix_line_end;
	// memory writes
	logic                         wr_en;
	logic [WR_ADDR_W-1:0]         wr_addr;
	logic [cam_pkg::PIXEL_W-1:0]  wr_data;

	// ======================================================================
	// capture pipeline
	// ======================================================================

	cam_sync_decode cam_sync_decode_i (
		.PCLK        (PCLK),
		.reset       (reset),
		.vsync       (vsync),
		.href        (href),
		.cam_data    (cam_data),
		.pair_valid  (pair_valid),
		.pair        (pair),
		.frame_start (frame_start),
		.line_end    (line_end)
	);

	pixel_downsample pixel_downsample_i (
		.PCLK            (PCLK),
		.reset           (reset),
		.pair_valid      (pair_valid),
		.pair            (pair),
		.frame_start     (frame_start),
		.line_end        (line_end),
		.pixel_valid     (pixel_valid),
		.pixel           (pixel),
		.pix_frame_start (pix_frame_start),
		.pix_line_end    (pix_line_end)
	);

	frame_write_addr #(
		.SCREEN_WIDTH  (SCREEN_WIDTH),
		.SCREEN_HEIGHT (SCREEN_HEIGHT)
	) frame_write_addr_i (
		.PCLK            (PCLK),
		.reset           (reset),
		.pixel_valid     (pixel_valid),
		.pixel           (pixel),
		.pix_frame_start (pix_frame_start),
		.pix_line_end    (pix_line_end),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data)
	);

	// buffer, read back by the host
	frame_buffer #(
		.SCREEN_WIDTH  (SCREEN_WIDTH),
		.SCREEN_HEIGHT (SCREEN_HEIGHT)
	) frame_buffer_i (
		.PCLK    (PCLK),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

endmodule

`default_nettype wire

/* test/cam_capture_checker.sv */
// frame buffer reference model fed from the camera pins, APB read comparison
`timescale 1ns/1ns
`default_nettype none

module cam_capture_checker #(
	parameter int SCREEN_WIDTH  = 8,
	parameter int SCREEN_HEIGHT = 4
) (
	input  wire                            PCLK,
	input  wire                            reset,
	input  wire                            vsync,
	input  wire                            href,
	input  wire [cam_pkg::BYTE_W-1:0]      cam_data,
	input  wire                            psel,
	input  wire                            penable,
	input  wire                            pwrite,
	input  wire [cam_pkg::APB_ADDR_W-1:0]  paddr,
	input  wire [cam_pkg::APB_DATA_W-1:0]  prdata,
	input  wire                            pready,
	input  wire                            pslverr,
	input  int                             test_id,
	input  wire                            exp_err,
	output int                             tests_passed,
	output int                             tests_failed,
	output int                             errors
);

	localparam int FRAME_SIZE = SCREEN_WIDTH * SCREEN_HEIGHT;

	// model of the pixel memory
	logic [7:0]  model [FRAME_SIZE];
	logic        vsync_q;
	logic        href_q;
	logic        phase;
	logic [7:0]  first_byte;
	logic [15:0] pair;
	int          x;
	int          y;
	// access cycles seen in the current transfer
	int          acc_cycles;
	logic        reset_seen;

	// compare one finished transfer against the model
	task automatic check_transfer();
		logic [31:0] exp_data;
		int          fails;
		fails = 0;
		// writes and out-of-range reads return zero
		if (pwrite || int'(paddr) >= FRAME_SIZE) begin
			exp_data = '0;
		end else begin
			exp_data = {24'h0, model[paddr]};
		end
		if (acc_cycles != 2) begin
			$display("Error at %0t: pready access cycle expected 2, got %0d", $time, acc_cycles);
			fails++;
		end
		if (pslverr !== exp_err) begin
			$display("Error at %0t: pslverr expected %b, got %b", $time, exp_err, pslverr);
			fails++;
		end
		if (prdata !== exp_data) begin
			$display("Error at %0t: prdata expected %h, got %h", $time, exp_data, prdata);
			fails++;
		end
		errors += fails;
		if (fails == 0) begin
			tests_passed++;
			$display("test %0d: index %0d passed", test_id, paddr);
		end else begin
			tests_failed++;
			$display("test %0d: index %0d failed", test_id, paddr);
		end
	endtask

	always @(posedge PCLK) begin
		if (reset) begin
			for (int i = 0; i < FRAME_SIZE; i++) begin
				model[i] = '0;
			end
			vsync_q      = 1'b0;
			href_q       = 1'b0;
			phase        = 1'b0;
			x            = 0;
			y            = 0;
			acc_cycles   = 0;
			tests_passed = 0;
			tests_failed = 0;
			errors       = 0;
			reset_seen   = 1'b1;
		end else begin
			// APB outputs must be idle on the first edge out of reset
			if (reset_seen) begin
				reset_seen = 1'b0;
				if (pready !== 1'b0) begin
					$display("Error at %0t: pready expected 0, got %b", $time, pready);
					errors++;
				end
				if (pslverr !== 1'b0) begin
					$display("Error at %0t: pslverr expected 0, got %b", $time, pslverr);
					errors++;
				end
			end

			// ==============================================================
			// APB transfer tracking
			// ==============================================================
			if (psel && penable) begin
				acc_cycles++;
				if (pready) begin
					check_transfer();
				end else if (acc_cycles == 3) begin
					$display("test %0d: pready never came, transfer at index %0d hung",
						test_id, paddr);
					errors++;
					tests_failed++;
				end
			end else begin
				acc_cycles = 0;
			end

			// ==============================================================
			// camera model writes at once on the second byte
			// ==============================================================
			if (vsync && !vsync_q) begin
				x     = 0;
				y     = 0;
				phase = 1'b0;
			end else if (!href && href_q) begin
				// odd trailing byte is lost here
				x     = 0;
				phase = 1'b0;
				if (y < SCREEN_HEIGHT) begin
					y++;
				end
			end else if (href) begin
				if (!phase) begin
					first_byte = cam_data;
					phase      = 1'b1;
				end else begin
					pair  = {cam_data, first_byte};
					phase = 1'b0;
					// r 3 msbs, g 3 msbs, b 2 msbs
					if (x < SCREEN_WIDTH && y < SCREEN_HEIGHT) begin
						model[x + y * SCREEN_WIDTH] = {pair[15:13], pair[10:8], pair[4:3]};
					end
					if (x < SCREEN_WIDTH) begin
						x++;
					end
				end
			end
			vsync_q = vsync;
			href_q  = href;
		end
	end

endmodule

`default_nettype wire

/* test/tb_cam_capture.sv */
// testbench top: clock, reset, test table, camera and APB drivers, timeout
`timescale 1ns/1ns
`default_nettype none

module tb_cam_capture;

	localparam int SCREEN_WIDTH  = 8;
	localparam int SCREEN_HEIGHT = 4;
	localparam int NUM_TESTS     = 13;

	// table columns
	localparam int C_LINES = 0;
	localparam int C_BYTES = 1;
	localparam int C_INDEX = 2;
	localparam int C_WRITE = 3;
	localparam int C_ERR   = 4;

	// lines, bytes per line, APB index, write, expected pslverr
	// full frames, odd lines, long lines, tall frames, then error cases
	int test_tab [NUM_TESTS][5] = '{
		'{4, 16,   0, 0, 0},
		'{4, 16,  15, 0, 0},
		'{4, 16,  31, 0, 0},
		'{4, 15,   8, 0, 0},
		'{4, 15,   7, 0, 0},
		'{4, 20,   7, 0, 0},
		'{4, 20,   8, 0, 0},
		'{6, 16,  31, 0, 0},
		'{6, 16,   0, 0, 0},
		'{1, 16,  32, 0, 1},
		'{1, 16, 255, 0, 1},
		'{1, 16,  20, 1, 1},
		'{1, 16,  20, 0, 0}
	};

	logic                            PCLK;
	logic                            reset;
	logic                            vsync;
	logic                            href;
	logic [cam_pkg::BYTE_W-1:0]      cam_data;
	logic                            psel;
	logic                            penable;
	logic                            pwrite;
	logic [cam_pkg::APB_ADDR_W-1:0]  paddr;
	logic [cam_pkg::APB_DATA_W-1:0]  pwdata;
	logic [cam_pkg::APB_DATA_W-1:0]  prdata;
	logic                            pready;
	logic                            pslverr;
	int                              test_id;
	logic                            exp_err;
	int                              tests_passed;
	int                              tests_failed;
	int                              errors;
	logic [31:0]                     lfsr;
	int                              cycles = 0;
	int                              cycle_limit;

	always #2 PCLK = ~PCLK;

	cam_capture_top #(
		.SCREEN_WIDTH  (SCREEN_WIDTH),
		.SCREEN_HEIGHT (SCREEN_HEIGHT)
	) cam_capture_top_i (
		.PCLK(PCLK), .reset(reset), .vsync(vsync), .href(href), .cam_data(cam_data),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	cam_capture_checker #(
		.SCREEN_WIDTH  (SCREEN_WIDTH),
		.SCREEN_HEIGHT (SCREEN_HEIGHT)
	) checker_i (
		.PCLK(PCLK), .reset(reset), .vsync(vsync), .href(href), .cam_data(cam_data),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.test_id(test_id), .exp_err(exp_err), .tests_passed(tests_passed),
		.tests_failed(tests_failed), .errors(errors)
	);

	// ======================================================================
	// helpers
	// ======================================================================

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	// twice the per-row budget of lines * (bytes + 4) + 10
	function automatic int timeout_cycles();
		int sum;
		sum = 0;
		for (int i = 0; i < NUM_TESTS; i++) begin
			sum += test_tab[i][C_LINES] * (test_tab[i][C_BYTES] + 4) + 10;
		end
		return 2 * sum;
	endfunction

	// inputs change 1 ns after the edge
	task automatic tick();
		@(posedge PCLK);
		#1;
	endtask

	// one LFSR step per bit taken
	task automatic next_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			b    = {b[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic send_frame(input int lines, input int bytes);
		logic [7:0] b;
		tick();
		vsync = 1'b1;
		tick();
		tick();
		vsync = 1'b0;
		tick();
		for (int l = 0; l < lines; l++) begin
			for (int n = 0; n < bytes; n++) begin
				next_byte(b);
				cam_data = b;
				href     = 1'b1;
				tick();
			end
			href     = 1'b0;
			cam_data = '0;
			tick();
			tick();
		end
	endtask

	// setup, then access until pready or a give-up bound
	task automatic apb_access(input int idx, input logic wr);
		int waited;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = idx[15:0];
		pwdata  = lfsr;
		tick();
		penable = 1'b1;
		waited  = 0;
		do begin
			@(posedge PCLK);
			waited++;
		end while (!pready && waited < 4);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// hard stop
	always @(posedge PCLK) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run went past its limit of %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		PCLK        = 1'b0;
		reset       = 1'b1;
		vsync       = 1'b0;
		href        = 1'b0;
		cam_data    = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		test_id     = 0;
		exp_err     = 1'b0;
		lfsr        = 32'h249a;
		cycle_limit = timeout_cycles();
		repeat (2) @(posedge PCLK);
		#1;
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_id = t;
			exp_err = (test_tab[t][C_ERR] != 0);
			send_frame(test_tab[t][C_LINES], test_tab[t][C_BYTES]);
			repeat (4) tick();
			apb_access(test_tab[t][C_INDEX], test_tab[t][C_WRITE] != 0);
		end
		repeat (2) tick();
		$display("tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && tests_passed == NUM_TESTS) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hw/cam_pkg.sv
hw/cam_sync_decode.sv
hw/pixel_downsample.sv
hw/frame_write_addr.sv
hw/frame_buffer.sv
hw/cam_capture_top.sv
test/cam_capture_checker.sv
test/tb_cam_capture.sv
